//--- compile.f
verilog/dcache_pkg.sv
verilog/array_arbiter.sv
verilog/tag_data_array.sv
verilog/mem_arbiter.sv
verilog/port_ctrl.sv
verilog/dcache_top.sv
testbench/dcache_assert.sv
testbench/tb_dcache.sv

//--- Makefile
# Verilator build and run for the two-port data cache

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_dcache.sv
// testbench for the two-port data cache
// byte memory model, shadow-memory reference, directed and random traffic
`default_nettype none

module tb_dcache import dcache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD     = 20;
  localparam int          RESET_CYCLES   = 10;
  localparam logic [31:0] SEED           = 32'hdee3fe0b;
  localparam int          MAX_GNT_DELAY  = 3;
  localparam int          MAX_RD_DELAY   = 2;
  localparam int          RAND_REQS      = 40;
  localparam int          DIRECTED_REQS  = 16;
  localparam int          TOTAL_REQS     = DIRECTED_REQS + NUM_PORTS * RAND_REQS;
  // worst case is a refill queued behind the other port's refill
  localparam int          CYCLES_PER_REQ = 40;
  localparam int          TIMEOUT_CYCLES = TOTAL_REQS * CYCLES_PER_REQ + 100;

  logic                        clk;
  logic                        rst_n;
  core_req_t  [NUM_PORTS-1:0]  core_req;
  core_resp_t [NUM_PORTS-1:0]  core_resp;
  mem_req_t                    mem_req;
  mem_resp_t                   mem_resp = '0;

  // backing memory and the reference copy
  logic [7:0] mem_bytes [0:2**ADDR_WIDTH-1];
  logic [7:0] shadow    [0:2**ADDR_WIDTH-1];

  // memory model state
  logic                  rd_pending = 1'b0;
  logic [ADDR_WIDTH-1:0] rd_addr;
  int                    rd_delay;
  logic                  gnt_armed = 1'b0;
  int                    gnt_delay;
  int                    mem_reads = 0;

  // outstanding load per port
  logic [ADDR_WIDTH-1:0] load_addr [NUM_PORTS];
  int                    loads_issued [NUM_PORTS];
  int                    loads_done [NUM_PORTS];

  int cmp_checks = 0;
  int cmp_errors = 0;
  int test_errors = 0;
  int err_mark = 0;
  int tests_run = 0;
  int failed_tests = 0;
  int cycle_cnt = 0;

  dcache_top dcache_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .core_req_i  (core_req),
    .core_resp_o (core_resp),
    .mem_req_o   (mem_req),
    .mem_resp_i  (mem_resp)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // expected load word from the shadow copy in little endian byte order
  function automatic logic [WORD_WIDTH-1:0] ref_load(input logic [ADDR_WIDTH-1:0] addr);
    logic [WORD_WIDTH-1:0] word;
    logic [ADDR_WIDTH-1:0] base;
    base = addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
    for (int b = 0; b < WORD_BYTES; b++) begin
      word[8*b +: 8] = shadow[base + ADDR_WIDTH'(b)];
    end
    return word;
  endfunction

  function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
    logic [WORD_WIDTH-1:0] word;
    logic [ADDR_WIDTH-1:0] base;
    base = addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
    for (int b = 0; b < WORD_BYTES; b++) begin
      word[8*b +: 8] = mem_bytes[base + ADDR_WIDTH'(b)];
    end
    return word;
  endfunction

  function automatic logic outputs_quiet();
    return !(core_resp[0].data_gnt | core_resp[1].data_gnt |
             core_resp[0].rvalid | core_resp[1].rvalid | mem_req.valid);
  endfunction

  // ------------------------------
  // memory model
  // ------------------------------
  always @(negedge clk) begin : mem_model
    logic [LINE_WIDTH-1:0] line;
    logic [ADDR_WIDTH-1:0] base;
    mem_resp = '0;
    if (!rst_n) begin
      rd_pending = 1'b0;
      gnt_armed  = 1'b0;
    end else if (rd_pending) begin
      // read data after a random wait
      if (rd_delay == 0) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
          line[8*b +: 8] = mem_bytes[rd_addr + ADDR_WIDTH'(b)];
        end
        mem_resp.rvalid = 1'b1;
        mem_resp.rdata  = line;
        rd_pending      = 1'b0;
      end else begin
        rd_delay--;
      end
    end else if (mem_req.valid) begin
      if (!gnt_armed) begin
        gnt_delay = $urandom % (MAX_GNT_DELAY + 1);
        gnt_armed = 1'b1;
      end
      if (gnt_delay == 0) begin
        mem_resp.gnt = 1'b1;
        gnt_armed    = 1'b0;
        if (mem_req.we) begin
          base = mem_req.addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (mem_req.be[b]) begin
              mem_bytes[base + ADDR_WIDTH'(b)] = mem_req.wdata[8*b +: 8];
            end
          end
        end else begin
          rd_pending = 1'b1;
          rd_addr    = mem_req.addr;
          rd_delay   = $urandom % (MAX_RD_DELAY + 1);
          mem_reads++;
        end
      end else begin
        gnt_delay--;
      end
    end
  end

  // every rvalid is checked against the shadow memory
  always @(posedge clk) begin : compare
    logic [WORD_WIDTH-1:0] expected;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rst_n && core_resp[p].rvalid) begin
        cmp_checks++;
        assert (loads_issued[p] > loads_done[p]) else begin
          $display("ERROR: port %0d gave rvalid with no load outstanding", p);
          cmp_errors++;
        end
        expected = ref_load(load_addr[p]);
        assert (core_resp[p].rdata == expected) else begin
          $display("ERROR: core_resp_o[%0d].rdata got %h expected %h at addr %h",
                   p, core_resp[p].rdata, expected, load_addr[p]);
          cmp_errors++;
        end
        loads_done[p]++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: requests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------
  // one core request with the gnt to rvalid cycles of a load in lat
  task automatic issue_request(input int p, input logic we,
                               input logic [ADDR_WIDTH-1:0] addr,
                               input logic [WORD_BYTES-1:0] be,
                               input logic [WORD_WIDTH-1:0] wdata, output int lat);
    core_req_t             req;
    logic [ADDR_WIDTH-1:0] base;
    req.data_req = 1'b1;
    req.we       = we;
    req.addr     = addr;
    req.be       = be;
    req.wdata    = wdata;
    base         = addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
    lat          = 0;
    @(negedge clk);
    core_req[p] = req;
    do @(posedge clk); while (!core_resp[p].data_gnt);
    if (we) begin
      // store is final at its grant
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (be[b]) begin
          shadow[base + ADDR_WIDTH'(b)] = wdata[8*b +: 8];
        end
      end
    end else begin
      load_addr[p] = addr;
      loads_issued[p]++;
    end
    @(negedge clk);
    core_req[p] = '0;
    if (!we) begin
      do begin
        @(posedge clk);
        lat++;
      end while (!core_resp[p].rvalid);
    end
  endtask

  // small tag pool per port half so lines hit, miss and evict
  task automatic random_traffic(input int p, input int count);
    logic [TAG_WIDTH-1:0]   tag;
    logic [INDEX_WIDTH-1:0] index;
    logic                   word;
    logic                   we;
    logic [WORD_BYTES-1:0]  be;
    int                     lat;
    for (int i = 0; i < count; i++) begin
      tag   = {p[0], 5'b0, 2'($urandom % 3)};
      index = INDEX_WIDTH'($urandom % 4);
      word  = 1'($urandom % 2);
      we    = ($urandom % 3) == 0;
      be    = WORD_BYTES'($urandom);
      if (be == '0) begin
        be = 8'h01;
      end
      issue_request(p, we, {tag, index, word, 3'b000}, be, {$urandom, $urandom}, lat);
      repeat ($urandom % 3) @(negedge clk);
    end
  endtask

  task automatic check_value(input string name, input logic [WORD_WIDTH-1:0] got,
                             input logic [WORD_WIDTH-1:0] exp);
    assert (got == exp) else begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int err_now;
    @(negedge clk);
    err_now = test_errors + cmp_errors;
    tests_run++;
    if (err_now != err_mark) begin
      failed_tests++;
      $display("test %0d %s: FAIL, %0d errors", tests_run, name, err_now - err_mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_mark = err_now;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main
    int                    lat;
    int                    reads_mark;
    logic [WORD_WIDTH-1:0] wd;
    void'($urandom(SEED));
    core_req = '0;
    rst_n    = 1'b0;
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      mem_bytes[i] = 8'($urandom);
      shadow[i]    = mem_bytes[i];
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // idle after reset and then a cold load
    repeat (5) begin
      @(posedge clk);
      assert (outputs_quiet()) else begin
        $display("ERROR: handshake outputs active with no request driven");
        test_errors++;
      end
    end
    reads_mark = mem_reads;
    issue_request(0, 1'b0, 16'h0048, '0, '0, lat);
    check_value("mem_reads", 64'(mem_reads), 64'(reads_mark + 1));
    finish_test("reset and first load");

    // both words of the cached line and their hit timing
    reads_mark = mem_reads;
    issue_request(0, 1'b0, 16'h0040, '0, '0, lat);
    check_value("hit latency", 64'(lat), 64'd1);
    issue_request(0, 1'b0, 16'h0048, '0, '0, lat);
    check_value("hit latency", 64'(lat), 64'd1);
    check_value("mem_reads", 64'(mem_reads), 64'(reads_mark));
    finish_test("load hit");

    // partial stores on a hit and then on a miss
    wd = {$urandom, $urandom};
    issue_request(0, 1'b1, 16'h0048, 8'h0f, wd, lat);
    issue_request(0, 1'b0, 16'h0048, '0, '0, lat);
    check_value("memory word 0048", mem_word(16'h0048), ref_load(16'h0048));
    wd = {$urandom, $urandom};
    issue_request(1, 1'b1, 16'h4510, 8'hf0, wd, lat);
    reads_mark = mem_reads;
    issue_request(1, 1'b0, 16'h4510, '0, '0, lat);
    check_value("mem_reads", 64'(mem_reads), 64'(reads_mark + 1));
    check_value("memory word 4510", mem_word(16'h4510), ref_load(16'h4510));
    finish_test("store merge");

    // three lines in set 3 share two ways so the oldest one is replaced
    reads_mark = mem_reads;
    issue_request(1, 1'b0, 16'h1130, '0, '0, lat);
    issue_request(1, 1'b0, 16'h2138, '0, '0, lat);
    issue_request(1, 1'b0, 16'h3130, '0, '0, lat);
    check_value("mem_reads", 64'(mem_reads), 64'(reads_mark + 3));
    // the two newest lines stay cached
    issue_request(1, 1'b0, 16'h2130, '0, '0, lat);
    check_value("hit latency", 64'(lat), 64'd1);
    issue_request(1, 1'b0, 16'h3138, '0, '0, lat);
    check_value("hit latency", 64'(lat), 64'd1);
    // the evicted first line comes back over the second one
    issue_request(1, 1'b0, 16'h1138, '0, '0, lat);
    check_value("mem_reads", 64'(mem_reads), 64'(reads_mark + 4));
    issue_request(1, 1'b0, 16'h3130, '0, '0, lat);
    check_value("hit latency", 64'(lat), 64'd1);
    finish_test("victim replacement");

    // both ports at once on disjoint halves
    fork
      random_traffic(0, RAND_REQS);
      random_traffic(1, RAND_REQS);
    join
    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value("loads_done", 64'(loads_done[p]), 64'(loads_issued[p]));
    end
    finish_test("random dual port");

    $display("summary: %0d tests, %0d failed, %0d data checks, %0d errors",
             tests_run, failed_tests, cmp_checks, test_errors + cmp_errors);
    if (test_errors + cmp_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/dcache_assert.sv
// protocol checks for the data cache
// array grant exclusivity, memory request stability, rvalid source state
`default_nettype none

module dcache_assert import dcache_pkg::*; (
  input wire logic                 clk_i,
  input wire logic                 rst_n_i,
  input wire logic [NUM_PORTS-1:0] arr_gnt_i,
  input wire logic [NUM_PORTS-1:0] arr_vld_i,
  input wire mem_req_t             mem_req_i,
  input wire logic                 mem_gnt_i,
  input wire logic [NUM_PORTS-1:0] rvalid_i,
  input wire logic [NUM_PORTS-1:0] held_we_i,
  input wire ctrl_state_e          state0_i,
  input wire ctrl_state_e          state1_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // the array takes one access per cycle and only from a port that asks
  one_array_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(arr_gnt_i) && ((arr_gnt_i & ~arr_vld_i) == '0))
    else $error("array grant to more than one port or to a port without a request");

  // pending memory request holds all its fields
  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.valid && !mem_gnt_i |=> $stable(mem_req_i))
    else $error("memory request changed before its grant");

  // a load only completes out of a busy controller that holds a load
  rvalid_port0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i[0] |-> state0_i != IDLE && !held_we_i[0])
    else $error("port 0 rvalid while its controller is idle or holds a store");

  rvalid_port1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i[1] |-> state1_i != IDLE && !held_we_i[1])
    else $error("port 1 rvalid while its controller is idle or holds a store");

endmodule

bind dcache_top dcache_assert dcache_assert_i (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .arr_gnt_i (ctrl_arr_gnt),
  .arr_vld_i ({ctrl_arr_req[1].valid, ctrl_arr_req[0].valid}),
  .mem_req_i (mem_req_o),
  .mem_gnt_i (mem_resp_i.gnt),
  .rvalid_i  ({core_resp_o[1].rvalid, core_resp_o[0].rvalid}),
  .held_we_i ({g_port[1].port_ctrl_i.req_q.we, g_port[0].port_ctrl_i.req_q.we}),
  .state0_i  (g_port[0].port_ctrl_i.state_q),
  .state1_i  (g_port[1].port_ctrl_i.state_q)
);

`default_nettype wire

//--- verilog/dcache_top.sv
// two-port set-associative data cache
// per-port controllers share one tag/data array and one memory port
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // core side
  input  wire core_req_t [NUM_PORTS-1:0] core_req_i,
  output core_resp_t [NUM_PORTS-1:0]    core_resp_o,
  // backing memory
  output mem_req_t                      mem_req_o,
  input  wire mem_resp_t                mem_resp_i
);

  // per-port array traffic
  array_req_t  [NUM_PORTS-1:0] ctrl_arr_req;
  logic        [NUM_PORTS-1:0] ctrl_arr_gnt;
  array_resp_t [NUM_PORTS-1:0] ctrl_arr_resp;
  // per-port memory traffic
  mem_req_t    [NUM_PORTS-1:0] ctrl_mem_req;
  mem_resp_t   [NUM_PORTS-1:0] ctrl_mem_resp;
  // single array port
  array_req_t                  arr_req;
  array_resp_t                 arr_resp;

  // ------------------------------
  // shared array
  // ------------------------------
  array_arbiter array_arbiter_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ctrl_arr_req),
    .gnt_o      (ctrl_arr_gnt),
    .resp_o     (ctrl_arr_resp),
    .arr_req_o  (arr_req),
    .arr_resp_i (arr_resp)
  );

  tag_data_array tag_data_array_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (arr_req),
    .resp_o  (arr_resp)
  );

  // ------------------------------
  // memory port
  // ------------------------------
  mem_arbiter mem_arbiter_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ctrl_mem_req),
    .resp_o     (ctrl_mem_resp),
    .mem_req_o  (mem_req_o),
    .mem_resp_i (mem_resp_i)
  );

  // one controller per core port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    port_ctrl port_ctrl_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .core_req_i  (core_req_i[p]),
      .core_resp_o (core_resp_o[p]),
      .arr_req_o   (ctrl_arr_req[p]),
      .arr_gnt_i   (ctrl_arr_gnt[p]),
      .arr_resp_i  (ctrl_arr_resp[p]),
      .mem_req_o   (ctrl_mem_req[p]),
      .mem_resp_i  (ctrl_mem_resp[p])
    );
  end

endmodule

`default_nettype wire

//--- verilog/port_ctrl.sv
// per-port cache controller
// loads with refill on miss, write-through stores with array update on hit
`default_nettype none

module port_ctrl import dcache_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  // core port
  input  wire core_req_t   core_req_i,
  output core_resp_t       core_resp_o,
  // tag/data array via arbiter
  output array_req_t       arr_req_o,
  input  wire logic        arr_gnt_i,
  input  wire array_resp_t arr_resp_i,
  // memory via arbiter
  output mem_req_t         mem_req_o,
  input  wire mem_resp_t   mem_resp_i
);

  ctrl_state_e state_q, state_d;

  // accepted request, hit way of a store, refill line
  core_req_t             req_q, req_d;
  logic [NUM_WAYS-1:0]   hit_way_q, hit_way_d;
  logic [LINE_WIDTH-1:0] line_q, line_d;

  logic [INDEX_WIDTH-1:0]    req_index;
  logic [TAG_WIDTH-1:0]      req_tag;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic [WORD_WIDTH-1:0]     hit_word;
  logic [WORD_WIDTH-1:0]     refill_word;
  logic [LINE_BYTES-1:0]     store_be;
  logic [LINE_WIDTH-1:0]     store_line;

  // address fields of the held request
  assign req_index = req_q.addr[BYTE_OFFSET +: INDEX_WIDTH];
  assign req_tag   = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign word_sel  = req_q.addr[BYTE_OFFSET-1:WORD_OFFSET];

  // word out of the hit line or the refill line
  assign hit_word    = arr_resp_i.rdata[word_sel*WORD_WIDTH +: WORD_WIDTH];
  assign refill_word = line_q[word_sel*WORD_WIDTH +: WORD_WIDTH];

  // store data placed at its word inside the line
  assign store_be   = LINE_BYTES'(req_q.be) << (word_sel * WORD_BYTES);
  assign store_line = {WORDS_PER_LINE{req_q.wdata}};

  // ------------------------------
  // controller FSM
  // ------------------------------
  always_comb begin : ctrl_fsm
    state_d   = state_q;
    req_d     = req_q;
    hit_way_d = hit_way_q;
    line_d    = line_q;
    // outputs idle unless a state drives them
    core_resp_o = '0;
    arr_req_o   = '0;
    mem_req_o   = '0;

    case (state_q)
      IDLE: begin
        // every request starts with a lookup
        if (core_req_i.data_req) begin
          arr_req_o.valid = 1'b1;
          arr_req_o.index = core_req_i.addr[BYTE_OFFSET +: INDEX_WIDTH];
          arr_req_o.tag   = core_req_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
          if (arr_gnt_i) begin
            req_d   = core_req_i;
            state_d = WAIT_TAG;
            // loads are granted now, stores once memory takes them
            core_resp_o.data_gnt = !core_req_i.we;
          end
        end
      end

      WAIT_TAG: begin
        // lookup result is here exactly one cycle after the grant
        if (req_q.we) begin
          hit_way_d = arr_resp_i.hit_way;
          state_d   = arr_resp_i.hit ? STORE_REQ : MEM_WRITE;
        end else if (arr_resp_i.hit) begin
          core_resp_o.rvalid = 1'b1;
          core_resp_o.rdata  = hit_word;
          state_d            = IDLE;
        end else begin
          state_d = REFILL_REQ;
        end
      end

      STORE_REQ: begin
        // byte-enabled write into the way that hit
        arr_req_o.valid = 1'b1;
        arr_req_o.we    = 1'b1;
        arr_req_o.index = req_index;
        arr_req_o.tag   = req_tag;
        arr_req_o.way   = hit_way_q;
        arr_req_o.be    = store_be;
        arr_req_o.wdata = store_line;
        if (arr_gnt_i) begin
          state_d = MEM_WRITE;
        end
      end

      MEM_WRITE: begin
        // write-through, every store ends here
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = req_q.addr;
        mem_req_o.be    = req_q.be;
        mem_req_o.wdata = req_q.wdata;
        if (mem_resp_i.gnt) begin
          core_resp_o.data_gnt = 1'b1;
          state_d              = IDLE;
        end
      end

      REFILL_REQ: begin
        // whole-line read, line aligned
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = {req_q.addr[ADDR_WIDTH-1:BYTE_OFFSET], {BYTE_OFFSET{1'b0}}};
        if (mem_resp_i.gnt) begin
          state_d = REFILL_WAIT;
        end
      end

      REFILL_WAIT: begin
        if (mem_resp_i.rvalid) begin
          line_d  = mem_resp_i.rdata;
          state_d = REFILL_WRITE;
        end
      end

      REFILL_WRITE: begin
        // array picks the victim way itself
        arr_req_o.valid  = 1'b1;
        arr_req_o.we     = 1'b1;
        arr_req_o.refill = 1'b1;
        arr_req_o.index  = req_index;
        arr_req_o.tag    = req_tag;
        arr_req_o.be     = '1;
        arr_req_o.wdata  = line_q;
        // load completes with the refill write
        if (arr_gnt_i) begin
          core_resp_o.rvalid = 1'b1;
          core_resp_o.rdata  = refill_word;
          state_d            = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_i) begin : state_reg
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : payload_reg
    req_q     <= req_d;
    hit_way_q <= hit_way_d;
    line_q    <= line_d;
  end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
// round-robin owner of the backing memory port
// ownership lasts until a write is granted or a read returns its line
`default_nettype none

module mem_arbiter import dcache_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // controller side
  input  wire mem_req_t [NUM_PORTS-1:0] req_i,
  output mem_resp_t [NUM_PORTS-1:0]     resp_o,
  // memory side
  output mem_req_t                      mem_req_o,
  input  wire mem_resp_t                mem_resp_i
);

  logic                  busy_q;
  logic [PORT_WIDTH-1:0] owner_q;
  logic [PORT_WIDTH-1:0] ptr_q;

  logic [NUM_PORTS-1:0]  valid_vec;
  logic [PORT_WIDTH-1:0] pick;
  logic [PORT_WIDTH-1:0] sel;
  logic                  start;
  logic                  done;

  always_comb begin : collect_valid
    for (int i = 0; i < NUM_PORTS; i++) begin
      valid_vec[i] = req_i[i].valid;
    end
  end

  // free port takes a new owner straight away
  assign pick      = rr_pick(valid_vec, ptr_q);
  assign sel       = busy_q ? owner_q : pick;
  assign start     = !busy_q && (|valid_vec);
  assign mem_req_o = req_i[sel];

  // transaction end, write at grant or read at data
  assign done = (mem_resp_i.gnt && mem_req_o.valid && mem_req_o.we) ||
                (busy_q && mem_resp_i.rvalid);

  // non-owners see everything low
  always_comb begin : resp_route
    for (int i = 0; i < NUM_PORTS; i++) begin
      resp_o[i] = ((busy_q || start) && (sel == PORT_WIDTH'(i))) ? mem_resp_i : '0;
    end
  end

  always_ff @(posedge clk_i) begin : owner_reg
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      ptr_q   <= '0;
    end else begin
      if (start) begin
        owner_q <= pick;
        ptr_q   <= rr_next(pick);
      end
      // a write granted in its first cycle never locks the port
      if (start && !done) begin
        busy_q <= 1'b1;
      end else if (busy_q && done) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/tag_data_array.sv
// two-way tag, valid and data storage
// registered tag compare, per-set victim bit for refills
`default_nettype none

module tag_data_array import dcache_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire array_req_t req_i,
  output array_resp_t     resp_o
);

  logic [TAG_WIDTH-1:0]  tag_mem  [NUM_WAYS][NUM_SETS];
  logic [LINE_WIDTH-1:0] data_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  // next way to replace in each set
  logic [NUM_SETS-1:0]   victim_q;

  // read registered for the compare cycle
  logic                   rd_vld_q;
  logic [INDEX_WIDTH-1:0] rd_index_q;
  logic [TAG_WIDTH-1:0]   rd_tag_q;

  logic                rd_en;
  logic                wr_en;
  logic                victim_way;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [NUM_WAYS-1:0] wr_match;

  assign rd_en      = req_i.valid && !req_i.we;
  assign wr_en      = req_i.valid && req_i.we;
  assign victim_way = victim_q[req_i.index];

  // ------------------------------
  // tag compare, one cycle after the read
  // ------------------------------
  always_comb begin : tag_compare
    resp_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = rd_vld_q && valid_q[w][rd_index_q] && (tag_mem[w][rd_index_q] == rd_tag_q);
      if (hit_vec[w]) begin
        resp_o.rdata = resp_o.rdata | data_mem[w][rd_index_q];
      end
    end
    resp_o.hit     = |hit_vec;
    resp_o.hit_way = hit_vec;
  end

  // store lands only if the way still holds that line
  always_comb begin : store_match
    for (int w = 0; w < NUM_WAYS; w++) begin
      wr_match[w] = req_i.way[w] && valid_q[w][req_i.index] &&
                    (tag_mem[w][req_i.index] == req_i.tag);
    end
  end

  always_ff @(posedge clk_i) begin : ctrl_reg
    if (!rst_n_i) begin
      valid_q  <= '0;
      victim_q <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_en;
      // refill claims the victim and moves the pointer on
      if (wr_en && req_i.refill) begin
        valid_q[victim_way][req_i.index] <= 1'b1;
        victim_q[req_i.index]            <= ~victim_way;
      end
    end
  end

  always_ff @(posedge clk_i) begin : mem_write
    if (rd_en) begin
      rd_index_q <= req_i.index;
      rd_tag_q   <= req_i.tag;
    end
    if (wr_en && req_i.refill) begin
      tag_mem[victim_way][req_i.index]  <= req_i.tag;
      data_mem[victim_way][req_i.index] <= req_i.wdata;
    end else if (wr_en) begin
      // byte merge into the hit way
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (wr_match[w] && req_i.be[b]) begin
            data_mem[w][req_i.index][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/array_arbiter.sv
// round-robin arbiter in front of the tag/data array
// routes each lookup result back to the port that was granted the read
`default_nettype none

module array_arbiter import dcache_pkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  // controller side
  input  wire array_req_t [NUM_PORTS-1:0] req_i,
  output logic [NUM_PORTS-1:0]            gnt_o,
  output array_resp_t [NUM_PORTS-1:0]     resp_o,
  // array side
  output array_req_t                      arr_req_o,
  input  wire array_resp_t                arr_resp_i
);

  logic [NUM_PORTS-1:0]  valid_vec;
  logic                  any_valid;
  logic [PORT_WIDTH-1:0] pick;
  logic [PORT_WIDTH-1:0] ptr_q;
  // port owed a lookup result this cycle
  logic [PORT_WIDTH-1:0] resp_sel_q;
  logic                  resp_vld_q;

  always_comb begin : collect_valid
    for (int i = 0; i < NUM_PORTS; i++) begin
      valid_vec[i] = req_i[i].valid;
    end
  end

  assign any_valid = |valid_vec;
  assign pick      = rr_pick(valid_vec, ptr_q);
  assign arr_req_o = any_valid ? req_i[pick] : '0;

  // one grant level per cycle, winner only
  always_comb begin : grant_out
    for (int i = 0; i < NUM_PORTS; i++) begin
      gnt_o[i] = any_valid && (pick == PORT_WIDTH'(i));
    end
  end

  // result reaches the reader only, others see zero
  always_comb begin : resp_route
    for (int i = 0; i < NUM_PORTS; i++) begin
      resp_o[i] = (resp_vld_q && (resp_sel_q == PORT_WIDTH'(i))) ? arr_resp_i : '0;
    end
  end

  always_ff @(posedge clk_i) begin : arb_reg
    if (!rst_n_i) begin
      ptr_q      <= '0;
      resp_sel_q <= '0;
      resp_vld_q <= 1'b0;
    end else begin
      // writes return nothing
      resp_vld_q <= any_valid && !arr_req_o.we;
      if (any_valid) begin
        ptr_q      <= rr_next(pick);
        resp_sel_q <= pick;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
// dcache shared definitions
// geometry, request/response structs, controller states, round-robin helpers
`default_nettype none

package dcache_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int NUM_PORTS      = 2;
  localparam int PORT_WIDTH     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int ADDR_WIDTH     = 16;
  localparam int LINE_WIDTH     = 128;
  localparam int WORD_WIDTH     = 64;
  localparam int BYTE_OFFSET    = 4;
  localparam int INDEX_WIDTH    = 4;
  localparam int TAG_WIDTH      = 8;
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 2 ** INDEX_WIDTH;
  localparam int LINE_BYTES     = LINE_WIDTH / 8;
  localparam int WORD_BYTES     = WORD_WIDTH / 8;
  localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
  // low address bits that select a byte inside a word
  localparam int WORD_OFFSET    = $clog2(WORD_BYTES);
  // address bits that select the word inside a line
  localparam int WORD_SEL_WIDTH = BYTE_OFFSET - WORD_OFFSET;

  // ------------------------------
  // structs
  // ------------------------------
  typedef struct packed {
    logic                  data_req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_BYTES-1:0] be;
    logic [WORD_WIDTH-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic                  data_gnt;
    logic                  rvalid;
    logic [WORD_WIDTH-1:0] rdata;
  } core_resp_t;

  // one access to the tag/data array, a read when we is low
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic                   refill;
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   tag;
    logic [NUM_WAYS-1:0]    way;
    logic [LINE_BYTES-1:0]  be;
    logic [LINE_WIDTH-1:0]  wdata;
  } array_req_t;

  typedef struct packed {
    logic                  hit;
    logic [NUM_WAYS-1:0]   hit_way;
    logic [LINE_WIDTH-1:0] rdata;
  } array_resp_t;

  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_BYTES-1:0] be;
    logic [WORD_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [LINE_WIDTH-1:0] rdata;
  } mem_resp_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_TAG,
    STORE_REQ,
    MEM_WRITE,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_WRITE
  } ctrl_state_e;

  // ------------------------------
  // round-robin helpers
  // ------------------------------
  // first requester at or after ptr, wrapping around
  function automatic logic [PORT_WIDTH-1:0] rr_pick(input logic [NUM_PORTS-1:0] valid,
                                                    input logic [PORT_WIDTH-1:0] ptr);
    logic [PORT_WIDTH-1:0] pick;
    int unsigned           idx;
    pick = ptr;
    // walk backwards so the closest requester is written last
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % NUM_PORTS;
      if (valid[idx]) begin
        pick = PORT_WIDTH'(idx);
      end
    end
    return pick;
  endfunction

  function automatic logic [PORT_WIDTH-1:0] rr_next(input logic [PORT_WIDTH-1:0] cur);
    return (int'(cur) == NUM_PORTS - 1) ? '0 : PORT_WIDTH'(int'(cur) + 1);
  endfunction

endpackage

`default_nettype wire
